//--- az_config_regs.sv
/*
  host-written configuration registers for the auto-zero sequencer
  one field is updated per write strobe, selected by the address,
  and the data is truncated to the width of that field
*/
`timescale 1ns/1ps
`default_nettype none

module az_config_regs (
  input  logic               clk,
  input  logic               reset,
  input  logic               cfg_wr_valid,
  input  az_pkg::cfg_write_t cfg_wr,
  output az_pkg::az_config_t cfg
);

  ////////////////////////////////////////////////////////////////////////////
  // write decode

  // strobe is a single cycle with no handshake, so every write lands here
  // on the edge where cfg_wr_valid is high and is visible the next cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      // counts of one and run clear until the host writes
      cfg <= az_pkg::CFG_DEFAULT;
    end
    else if (cfg_wr_valid)
    begin
      case (cfg_wr.addr)
        az_pkg::CFG_ADDR_PRECHARGE:
        begin
          // length of protect, settle and reprotect
          cfg.precharge_n <= cfg_wr.data;
        end
        az_pkg::CFG_ADDR_SAMPLE:
        begin
          // length of the signal and zero windows
          cfg.sample_n <= cfg_wr.data;
        end
        az_pkg::CFG_ADDR_LO_MUX:
        begin
          // upper data bits are dropped
          cfg.lo_mux <= cfg_wr.data[az_pkg::MUX_W-1:0];
        end
        az_pkg::CFG_ADDR_RUN:
        begin
          // only bit 0 matters
          cfg.run <= cfg_wr.data[0];
        end
      endcase
    end
  end

  // the sequencer reads new counts and lo_mux only when a phase loads them,
  // so a write in mid-phase never disturbs the phase in progress

endmodule

`default_nettype wire

//--- az_modulation.f
az_pkg.sv
az_config_regs.sv
az_sequencer.sv
az_sample_accum.sv
az_modulation_top.sv
az_modulation_assertions.sv
tb_az_modulation.sv

//--- az_modulation_assertions.sv
/*
  concurrent checks on the auto-zero sequencer, bound into az_sequencer
  fail_count lets the testbench notice any failure
*/
`timescale 1ns/1ps
`default_nettype none

module az_modulation_assertions (
  input logic                       clk,
  input logic                       reset,
  input az_pkg::az_phase_t          ph,
  input logic [az_pkg::COUNT_W-1:0] count_down,
  input logic                       sw_pc_ctl,
  input logic [az_pkg::MUX_W-1:0]   azmux
);

  int unsigned fail_count = 0;

  // a phase loaded with more than one cycle cannot start again next cycle
  start_spacing: assert property (@(posedge clk) disable iff (reset)
    (ph.phase_start && count_down > az_pkg::COUNT_ONE) |=> !ph.phase_start)
  else
  begin
    fail_count++;
    $error("phase_start high in two cycles with a count above one");
  end

  // precharge switch on the signal only while sampling the signal
  switch_in_signal: assert property (@(posedge clk) disable iff (reset)
    (sw_pc_ctl == az_pkg::SW_PC_SIGNAL) |-> (ph.phase == az_pkg::PH_SIGNAL))
  else
  begin
    fail_count++;
    $error("sw_pc_ctl at signal level outside the signal phase");
  end

  // az mux parked on the precharge output for settle and signal
  mux_parked: assert property (@(posedge clk) disable iff (reset)
    (ph.phase == az_pkg::PH_SETTLE || ph.phase == az_pkg::PH_SIGNAL)
      |-> (azmux == az_pkg::MUX_PC_OUT))
  else
  begin
    fail_count++;
    $error("azmux left the precharge output during settle or signal");
  end

endmodule

bind az_sequencer az_modulation_assertions az_modulation_assertions_i (
  .clk        (clk),
  .reset      (reset),
  .ph         (ph),
  .count_down (count_down),
  .sw_pc_ctl  (sw_pc_ctl),
  .azmux      (azmux)
);

`default_nettype wire

//--- az_modulation_top.sv
/*
  auto-zero modulation block, top level
  config registers feed the sequencer, which drives the switches and
  tells the accumulator which sample window is open
*/
`timescale 1ns/1ps
`default_nettype none

module az_modulation_top (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cfg_wr_valid,
  input  az_pkg::cfg_write_t       cfg_wr,
  input  logic                     comp,
  output logic                     sw_pc_ctl,
  output logic [az_pkg::MUX_W-1:0] azmux,
  output logic                     led0,
  output logic [7:0]               monitor,
  output logic                     result_valid,
  output az_pkg::az_result_t       result
);

  az_pkg::az_config_t cfg;
  az_pkg::az_phase_t  ph;

  // host register block
  az_config_regs az_config_regs_i (
    .clk          (clk),
    .reset        (reset),
    .cfg_wr_valid (cfg_wr_valid),
    .cfg_wr       (cfg_wr),
    .cfg          (cfg)
  );

  // phase state machine
  az_sequencer az_sequencer_i (
    .clk       (clk),
    .reset     (reset),
    .cfg       (cfg),
    .sw_pc_ctl (sw_pc_ctl),
    .azmux     (azmux),
    .led0      (led0),
    .monitor   (monitor),
    .ph        (ph)
  );

  // comparator counting per window
  az_sample_accum az_sample_accum_i (
    .clk          (clk),
    .reset        (reset),
    .ph           (ph),
    .comp         (comp),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

`default_nettype wire

//--- az_pkg.sv
/*
  shared definitions for the auto-zero modulation block
  phase codes, register map, field widths and the packed structs
  that travel between the config registers, sequencer and accumulator
*/
`default_nettype none

package az_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  // phase lengths in clock cycles
  localparam int COUNT_W = 24;
  // lo mux select
  localparam int MUX_W = 4;

  // single count, used as reset default and as the floor for a programmed 0
  localparam logic [COUNT_W-1:0] COUNT_ONE = 1;

  ////////////////////////////////////////////////////////////////////////////
  // switch and mux encodings

  // az mux pin that routes the precharge output, held for settle and signal
  localparam logic [MUX_W-1:0] MUX_PC_OUT = 4'b1000;

  // precharge switch, boot voltage protects the signal from az switch charge
  localparam logic SW_PC_BOOT = 1'b0;
  localparam logic SW_PC_SIGNAL = 1'b1;

  // register map for the host write strobe
  localparam logic [1:0] CFG_ADDR_PRECHARGE = 2'd0;
  localparam logic [1:0] CFG_ADDR_SAMPLE = 2'd1;
  localparam logic [1:0] CFG_ADDR_LO_MUX = 2'd2;
  localparam logic [1:0] CFG_ADDR_RUN = 2'd3;

  // phase codes, also shown on monitor[2:0]
  typedef enum logic [2:0] {
    PH_HALT      = 3'd0,
    PH_PROTECT   = 3'd1,
    PH_SETTLE    = 3'd2,
    PH_SIGNAL    = 3'd3,
    PH_REPROTECT = 3'd4,
    PH_ZERO      = 3'd5
  } az_phase_e;

  ////////////////////////////////////////////////////////////////////////////
  // structs

  // one host write, no back-pressure
  typedef struct packed {
    logic [1:0]         addr;
    logic [COUNT_W-1:0] data;
  } cfg_write_t;

  // register block contents as seen by the sequencer
  typedef struct packed {
    logic [COUNT_W-1:0] precharge_n;
    logic [COUNT_W-1:0] sample_n;
    logic [MUX_W-1:0]   lo_mux;
    logic               run;
  } az_config_t;

  // reset contents, counts of one and the sequencer stopped
  localparam az_config_t CFG_DEFAULT = '{
    precharge_n: COUNT_ONE,
    sample_n:    COUNT_ONE,
    lo_mux:      '0,
    run:         1'b0
  };

  // current phase, phase_start marks its first cycle
  typedef struct packed {
    az_phase_e phase;
    logic      phase_start;
  } az_phase_t;

  // one accumulated sample window
  typedef struct packed {
    logic               is_zero;
    logic [COUNT_W-1:0] count;
  } az_result_t;

endpackage

`default_nettype wire

//--- az_sample_accum.sv
/*
  sample window accumulator
  counts comparator-high cycles through each signal or zero phase and
  presents one result per window in the cycle after the window ends
*/
`timescale 1ns/1ps
`default_nettype none

module az_sample_accum (
  input  logic                clk,
  input  logic                reset,
  input  az_pkg::az_phase_t   ph,
  input  logic                comp,
  output logic                result_valid,
  output az_pkg::az_result_t  result
);

  // comparator hits in the current or just finished window
  logic [az_pkg::COUNT_W-1:0] acc;
  // phase seen in the previous cycle
  az_pkg::az_phase_e          last_phase;
  logic                       in_sample;
  logic                       was_sample;
  logic [az_pkg::COUNT_W-1:0] comp_ext;

  assign in_sample = (ph.phase == az_pkg::PH_SIGNAL) || (ph.phase == az_pkg::PH_ZERO);
  assign was_sample = (last_phase == az_pkg::PH_SIGNAL) || (last_phase == az_pkg::PH_ZERO);
  assign comp_ext = {{(az_pkg::COUNT_W-1){1'b0}}, comp};

  ////////////////////////////////////////////////////////////////////////////
  // window tracking

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      last_phase <= az_pkg::PH_HALT;
    else
      last_phase <= ph.phase;
  end

  ////////////////////////////////////////////////////////////////////////////
  // accumulator

  // the start cycle clears and counts in one step, so comp in the
  // phase_start cycle is already part of the total
  always_ff @(posedge clk)
  begin
    if (in_sample)
    begin
      if (ph.phase_start)
        acc <= comp_ext;
      else
        acc <= acc + comp_ext;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // result

  // a sample phase is always followed by a different phase, so a change
  // away from it marks the first cycle after the window; acc is not
  // touched again until the next window starts, at least one cycle later
  assign result_valid = was_sample && (ph.phase != last_phase);
  assign result.is_zero = (last_phase == az_pkg::PH_ZERO);
  assign result.count = acc;

endmodule

`default_nettype wire

//--- az_sequencer.sv
/*
  auto-zero phase sequencer
  walks protect once after reset, then loops settle, signal, reprotect
  and zero while run is set; drives the precharge switch, the lo mux,
  the activity led and a phase-code monitor for a logic analyzer
*/
`timescale 1ns/1ps
`default_nettype none

module az_sequencer (
  input  logic                     clk,
  input  logic                     reset,
  input  az_pkg::az_config_t       cfg,
  output logic                     sw_pc_ctl,
  output logic [az_pkg::MUX_W-1:0] azmux,
  output logic                     led0,
  output logic [7:0]               monitor,
  output az_pkg::az_phase_t        ph
);

  // cycles left in the current phase, 1 in the last cycle
  logic [az_pkg::COUNT_W-1:0] count_down;
  // set once the initial protect phase has been entered
  logic                       protect_done;
  logic                       last_cycle;
  logic                       advance;
  az_pkg::az_phase_e          next_phase;
  logic [az_pkg::COUNT_W-1:0] load_n;

  assign last_cycle = (count_down <= az_pkg::COUNT_ONE);

  ////////////////////////////////////////////////////////////////////////////
  // next phase

  always_comb
  begin
    next_phase = ph.phase;
    advance = 1'b0;
    case (ph.phase)
      az_pkg::PH_HALT:
      begin
        // first start after reset needs protect, later ones go to settle
        advance = cfg.run;
        next_phase = protect_done ? az_pkg::PH_SETTLE : az_pkg::PH_PROTECT;
      end
      az_pkg::PH_PROTECT:
      begin
        advance = last_cycle;
        next_phase = az_pkg::PH_SETTLE;
      end
      az_pkg::PH_SETTLE:
      begin
        advance = last_cycle;
        next_phase = az_pkg::PH_SIGNAL;
      end
      az_pkg::PH_SIGNAL:
      begin
        advance = last_cycle;
        next_phase = az_pkg::PH_REPROTECT;
      end
      az_pkg::PH_REPROTECT:
      begin
        advance = last_cycle;
        next_phase = az_pkg::PH_ZERO;
      end
      az_pkg::PH_ZERO:
      begin
        // run is only looked at here, so a stop always finishes the zero
        advance = last_cycle;
        next_phase = cfg.run ? az_pkg::PH_SETTLE : az_pkg::PH_HALT;
      end
      default:
      begin
        // unused codes fall back to halt
        advance = 1'b1;
        next_phase = az_pkg::PH_HALT;
      end
    endcase
  end

  // length of the phase about to start, taken from cfg at the load
  always_comb
  begin
    if (next_phase == az_pkg::PH_SIGNAL || next_phase == az_pkg::PH_ZERO)
      load_n = cfg.sample_n;
    else
      load_n = cfg.precharge_n;
    // a programmed 0 runs as a single cycle
    if (load_n == '0)
      load_n = az_pkg::COUNT_ONE;
  end

  ////////////////////////////////////////////////////////////////////////////
  // phase register, countdown and outputs

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      ph.phase <= az_pkg::PH_HALT;
      ph.phase_start <= 1'b0;
      count_down <= az_pkg::COUNT_ONE;
      protect_done <= 1'b0;
      sw_pc_ctl <= az_pkg::SW_PC_BOOT;
      azmux <= '0;
      led0 <= 1'b0;
    end
    else if (advance)
    begin
      ph.phase <= next_phase;
      // halt is a resting state and gets no start marker
      ph.phase_start <= (next_phase != az_pkg::PH_HALT);
      count_down <= load_n;
      // outputs change on the first cycle of the new phase
      case (next_phase)
        az_pkg::PH_PROTECT:
        begin
          sw_pc_ctl <= az_pkg::SW_PC_BOOT;
          protect_done <= 1'b1;
        end
        az_pkg::PH_SETTLE:
        begin
          // signal stays protected by pc while the az mux moves
          azmux <= az_pkg::MUX_PC_OUT;
        end
        az_pkg::PH_SIGNAL:
        begin
          sw_pc_ctl <= az_pkg::SW_PC_SIGNAL;
          led0 <= 1'b1;
        end
        az_pkg::PH_REPROTECT:
        begin
          sw_pc_ctl <= az_pkg::SW_PC_BOOT;
        end
        az_pkg::PH_ZERO:
        begin
          azmux <= cfg.lo_mux;
          led0 <= 1'b0;
        end
        default:
        begin
          // halt holds every output
          led0 <= led0;
        end
      endcase
    end
    else
    begin
      ph.phase_start <= 1'b0;
      // count stays put in halt
      if (ph.phase != az_pkg::PH_HALT)
        count_down <= count_down - az_pkg::COUNT_ONE;
    end
  end

  // bit 7 pulses on each phase start, bits 2:0 carry the phase code
  assign monitor = {ph.phase_start, 4'b0000, ph.phase};

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the auto-zero modulation testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_az_modulation \
  -f az_modulation.f

# a raised error limit lets the testbench see assertion failures itself
./obj_dir/Vtb_az_modulation +verilator+error+limit+100 | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- tb_az_modulation.sv
/*
  testbench for the auto-zero modulation block
  random comparator data and register writes, a cycle model of the
  phase rules, and a compare of every output on each falling edge
*/
`timescale 1ns/1ps
`default_nettype none

module tb_az_modulation;

  // worst-case loop, three precharge and two sample phases of 12 cycles
  localparam int LOOP_MAX = 3 * 12 + 2 * 12;
  // loops over all tests, rounded up
  localparam int TOTAL_LOOPS = 50;
  localparam int TIMEOUT_CYCLES = 2 * TOTAL_LOOPS * LOOP_MAX + 200;

  logic clk;
  logic reset;
  logic cfg_wr_valid;
  az_pkg::cfg_write_t cfg_wr;
  logic comp;
  logic sw_pc_ctl;
  logic [az_pkg::MUX_W-1:0] azmux;
  logic led0;
  logic [7:0] monitor;
  logic result_valid;
  az_pkg::az_result_t result;

  logic [31:0] lcg_state;
  int cycle_count = 0;
  int protect_seen;
  logic last_is_zero;

  // model state, updated once per rising edge
  az_pkg::az_config_t ref_cfg;
  az_pkg::az_phase_e ref_phase;
  logic ref_start;
  int ref_elapsed;
  int ref_len;
  logic ref_booted;
  logic ref_sw;
  logic [az_pkg::MUX_W-1:0] ref_azmux;
  logic ref_led;
  logic [az_pkg::COUNT_W-1:0] ref_acc;
  logic ref_valid;
  az_pkg::az_result_t ref_result;

  az_modulation_top az_modulation_top_i (
    .clk          (clk),
    .reset        (reset),
    .cfg_wr_valid (cfg_wr_valid),
    .cfg_wr       (cfg_wr),
    .comp         (comp),
    .sw_pc_ctl    (sw_pc_ctl),
    .azmux        (azmux),
    .led0         (led0),
    .monitor      (monitor),
    .result_valid (result_valid),
    .result       (result)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES)
    begin
      $display("timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $fatal(1, "simulation timed out");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  function automatic logic [31:0] rand_word();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper bits of the lcg, the low ones repeat quickly
  function automatic int rand_below(input int span);
    return int'((rand_word() >> 8) % 32'(span));
  endfunction

  function automatic logic is_sample(input az_pkg::az_phase_e p);
    return (p == az_pkg::PH_SIGNAL) || (p == az_pkg::PH_ZERO);
  endfunction

  // a programmed 0 still gives a one-cycle phase
  function automatic int phase_len(input logic [az_pkg::COUNT_W-1:0] n);
    if (n == '0)
      return 1;
    return int'(n);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "output mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  task automatic model_step();
    az_pkg::az_config_t old_cfg;
    az_pkg::az_phase_e old_phase;
    az_pkg::az_phase_e new_phase;
    logic old_start;
    logic enter;
    old_cfg = ref_cfg;
    old_phase = ref_phase;
    old_start = ref_start;
    new_phase = old_phase;
    enter = 1'b0;
    // host write lands on this edge, used from the next one
    if (cfg_wr_valid)
    begin
      case (cfg_wr.addr)
        az_pkg::CFG_ADDR_PRECHARGE: ref_cfg.precharge_n = cfg_wr.data;
        az_pkg::CFG_ADDR_SAMPLE: ref_cfg.sample_n = cfg_wr.data;
        az_pkg::CFG_ADDR_LO_MUX: ref_cfg.lo_mux = cfg_wr.data[3:0];
        default: ref_cfg.run = cfg_wr.data[0];
      endcase
    end
    // comp counts in every cycle of a sample window
    if (is_sample(old_phase))
      ref_acc = old_start ? 24'(comp) : ref_acc + 24'(comp);
    if (old_phase == az_pkg::PH_HALT)
    begin
      enter = old_cfg.run;
      if (ref_booted)
        new_phase = az_pkg::PH_SETTLE;
      else
        new_phase = az_pkg::PH_PROTECT;
    end
    else if (ref_elapsed + 1 >= ref_len)
    begin
      enter = 1'b1;
      case (old_phase)
        az_pkg::PH_PROTECT: new_phase = az_pkg::PH_SETTLE;
        az_pkg::PH_SETTLE: new_phase = az_pkg::PH_SIGNAL;
        az_pkg::PH_SIGNAL: new_phase = az_pkg::PH_REPROTECT;
        az_pkg::PH_REPROTECT: new_phase = az_pkg::PH_ZERO;
        default:
        begin
          if (old_cfg.run)
            new_phase = az_pkg::PH_SETTLE;
          else
            new_phase = az_pkg::PH_HALT;
        end
      endcase
    end
    if (enter)
    begin
      ref_phase = new_phase;
      ref_start = (new_phase != az_pkg::PH_HALT);
      ref_elapsed = 0;
      if (is_sample(new_phase))
        ref_len = phase_len(old_cfg.sample_n);
      else
        ref_len = phase_len(old_cfg.precharge_n);
      case (new_phase)
        az_pkg::PH_PROTECT:
        begin
          ref_sw = az_pkg::SW_PC_BOOT;
          ref_booted = 1'b1;
        end
        az_pkg::PH_SETTLE: ref_azmux = az_pkg::MUX_PC_OUT;
        az_pkg::PH_SIGNAL:
        begin
          ref_sw = az_pkg::SW_PC_SIGNAL;
          ref_led = 1'b1;
        end
        az_pkg::PH_REPROTECT: ref_sw = az_pkg::SW_PC_BOOT;
        az_pkg::PH_ZERO:
        begin
          ref_azmux = old_cfg.lo_mux;
          ref_led = 1'b0;
        end
        default: ref_start = 1'b0;
      endcase
    end
    else
    begin
      ref_start = 1'b0;
      ref_elapsed = ref_elapsed + 1;
    end
    // a window closes when the phase moves away from it
    ref_valid = is_sample(old_phase) && (ref_phase != old_phase);
    if (ref_valid)
    begin
      ref_result.is_zero = (old_phase == az_pkg::PH_ZERO);
      ref_result.count = ref_acc;
    end
  endtask

  task automatic compare_outputs();
    check_value("sw_pc_ctl", 32'(sw_pc_ctl), 32'(ref_sw));
    check_value("azmux", 32'(azmux), 32'(ref_azmux));
    check_value("led0", 32'(led0), 32'(ref_led));
    check_value("monitor", 32'(monitor), 32'({ref_start, 4'b0000, ref_phase}));
    check_value("result_valid", 32'(result_valid), 32'(ref_valid));
    check_value("assertion failures",
                32'(az_modulation_top_i.az_sequencer_i.az_modulation_assertions_i.fail_count),
                32'd0);
    if (result_valid)
    begin
      check_value("result.is_zero", 32'(result.is_zero), 32'(ref_result.is_zero));
      check_value("result.count", 32'(result.count), 32'(ref_result.count));
      // signal and zero windows take turns
      check_value("result.is_zero order", 32'(result.is_zero), 32'(!last_is_zero));
      last_is_zero = result.is_zero;
    end
    if (monitor[7] && monitor[2:0] == 3'(az_pkg::PH_PROTECT))
      protect_seen = protect_seen + 1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  // one clock: model on the rising edge, new inputs, compare on the falling edge
  task automatic tick(input logic wr_valid, input az_pkg::cfg_write_t wr);
    logic [31:0] r;
    @(posedge clk);
    model_step();
    r = rand_word();
    cfg_wr_valid <= wr_valid;
    cfg_wr <= wr;
    comp <= r[20];
    @(negedge clk);
    compare_outputs();
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) tick(1'b0, '0);
  endtask

  task automatic write_reg(input logic [1:0] addr, input int value);
    az_pkg::cfg_write_t wr;
    wr.addr = addr;
    wr.data = value[az_pkg::COUNT_W-1:0];
    tick(1'b1, wr);
  endtask

  task automatic write_random_config();
    write_reg(az_pkg::CFG_ADDR_PRECHARGE, 1 + rand_below(12));
    write_reg(az_pkg::CFG_ADDR_SAMPLE, 1 + rand_below(12));
    write_reg(az_pkg::CFG_ADDR_LO_MUX, rand_below(8));
  endtask

  task automatic wait_results(input int wanted);
    int seen;
    seen = 0;
    while (seen < wanted)
    begin
      tick(1'b0, '0);
      if (result_valid)
        seen = seen + 1;
    end
  endtask

  task automatic wait_halt();
    while (monitor[2:0] != 3'(az_pkg::PH_HALT) || ref_cfg.run)
      tick(1'b0, '0);
  endtask

  initial
  begin
    reset = 1'b1;
    cfg_wr_valid = 1'b0;
    cfg_wr = '0;
    comp = 1'b0;
    lcg_state = 32'hd6344458;
    protect_seen = 0;
    last_is_zero = 1'b1;
    // reset values, counts of one and the sequencer stopped
    ref_cfg.precharge_n = 24'd1;
    ref_cfg.sample_n = 24'd1;
    ref_cfg.lo_mux = 4'd0;
    ref_cfg.run = 1'b0;
    ref_phase = az_pkg::PH_HALT;
    ref_start = 1'b0;
    ref_elapsed = 0;
    ref_len = 1;
    ref_booted = 1'b0;
    ref_sw = az_pkg::SW_PC_BOOT;
    ref_azmux = 4'd0;
    ref_led = 1'b0;
    ref_acc = '0;
    ref_valid = 1'b0;
    ref_result = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    // idle after reset with run clear
    idle(20);
    // first start goes through protect
    write_random_config();
    write_reg(az_pkg::CFG_ADDR_RUN, 1);
    wait_results(4);
    // long run of random comparator data
    wait_results(40);
    // new counts and lo mux while running
    repeat (6)
    begin
      idle(rand_below(6));
      write_random_config();
      wait_results(4);
    end
    // stop after the zero phase, then resume at settle
    write_reg(az_pkg::CFG_ADDR_RUN, 0);
    wait_halt();
    idle(15);
    write_reg(az_pkg::CFG_ADDR_RUN, 1);
    wait_results(4);
    // programmed zero counts run as single cycles
    write_reg(az_pkg::CFG_ADDR_PRECHARGE, 0);
    write_reg(az_pkg::CFG_ADDR_SAMPLE, 0);
    wait_results(10);
    write_reg(az_pkg::CFG_ADDR_RUN, 0);
    wait_halt();
    idle(5);
    check_value("protect phases", 32'(protect_seen), 32'd1);
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire
